/* tb.f */
common/input_layer_pkg.sv
verilog/layer_sequencer.sv
verilog/ddr_row_reader.sv
verilog/row_buffer_bank.sv
verilog/window_output_stage.sv
verilog/input_layer_streamer.sv
test/ddr_read_model.sv
test/tb_input_layer.sv

/* Makefile */
# Verilator build and run for the input layer streamer testbench

SIM     ?= verilator
TOP     ?= tb_input_layer
VFLAGS  ?= --binary --timing -Wno-fatal
OBJ_DIR ?= obj_dir

SRCS := $(shell grep -v '^+' tb.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: tb.f $(SRCS)
	$(SIM) $(VFLAGS) --top-module $* -f tb.f --Mdir $(OBJ_DIR) -o V$*

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_input_layer.sv */
`default_nettype none

module tb_input_layer
	import input_layer_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic                clk = 1'b0;
	logic                reset_n = 1'b0;
	logic                start = 1'b0;
	logic [addr_w-1:0]   base_addr = '0;
	logic [dim_w-1:0]    num_layers = '0;
	logic [dim_w-1:0]    num_rows = '0;
	logic [dim_w-1:0]    num_cols = '0;
	logic                window_ready = 1'b0;
	logic [addr_w-1:0]   araddr;
	logic [7:0]          arlen;
	logic [2:0]          arsize;
	logic [1:0]          arburst;
	logic                arvalid;
	logic                arready;
	logic                rvalid;
	logic [data_w-1:0]   rdata;
	logic                rlast;
	logic                rready;
	logic [window_w-1:0] window_data;
	logic                window_valid;
	logic [dim_w-1:0]    window_layer;
	logic                busy;
	logic                done;

	int                  seed = 30710;
	int                  errors = 0;
	int                  tests_run = 0;
	int                  tests_failed = 0;
	int                  cycles = 0;
	int                  cycle_limit = 0;
	int                  done_count = 0;
	logic                bp_on = 1'b0;
	// test table
	string               t_name [5];
	logic [addr_w-1:0]   t_base [5];
	int                  t_layers [5];
	int                  t_rows [5];
	int                  t_cols [5];
	logic                t_bp [5];
	// reference queues
	logic [window_w-1:0] exp_win [$];
	logic [dim_w-1:0]    exp_layer [$];
	logic [addr_w-1:0]   exp_addr [$];
	logic [7:0]          exp_len = '0;
	// monitor state
	logic                burst_open = 1'b0;
	int                  beats_seen = 0;
	logic [7:0]          cur_len = '0;
	logic                stalled = 1'b0;
	logic [window_w-1:0] held_data = '0;
	logic [dim_w-1:0]    held_layer = '0;

	always #20 clk = ~clk;

	input_layer_streamer dut_i (
		.clk(clk), .reset_n(reset_n), .start(start), .base_addr(base_addr),
		.num_layers(num_layers), .num_rows(num_rows), .num_cols(num_cols),
		.araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
		.arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rdata(rdata),
		.rlast(rlast), .rready(rready), .window_data(window_data),
		.window_valid(window_valid), .window_ready(window_ready),
		.window_layer(window_layer), .busy(busy), .done(done)
	);

	ddr_read_model mem_i (
		.clk(clk), .reset_n(reset_n), .araddr(araddr), .arlen(arlen),
		.arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rdata(rdata),
		.rlast(rlast), .rready(rready)
	);

	task automatic mismatch(input string msg);
		errors++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	task automatic protocol_error(input string msg);
		errors++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [7:0] mem_byte(input logic [addr_w-1:0] a);
		return a[7:0] + a[15:8];
	endfunction

	// top row first with the left byte most significant and zero off the image
	function automatic logic [window_w-1:0] ref_window(input logic [addr_w-1:0] base,
		input int rows, input int cols, input int r, input int l, input int c);
		logic [window_w-1:0] w;
		int rr;
		int cc;
		w = '0;
		for (int i = 0; i < 9; i++) begin
			rr = r - 1 + i / 3;
			cc = c - 1 + i % 3;
			if (rr >= 0 && rr < rows && cc >= 0 && cc < cols) begin
				w[window_w-1-8*i -: 8] = mem_byte(base + addr_w'(l * 4096 + rr * 64 + cc));
			end
		end
		return w;
	endfunction

	// row outer then layer then column innermost
	task automatic build_expected(input int t);
		for (int r = 0; r < t_rows[t]; r++) begin
			for (int l = 0; l < t_layers[t]; l++) begin
				for (int rr = r - 1; rr <= r + 1; rr++) begin
					if (rr >= 0 && rr < t_rows[t]) begin
						exp_addr.push_back(t_base[t] + addr_w'(l * 4096 + rr * 64));
					end
				end
				for (int c = 0; c < t_cols[t]; c++) begin
					exp_win.push_back(ref_window(t_base[t], t_rows[t], t_cols[t], r, l, c));
					exp_layer.push_back(dim_w'(l));
				end
			end
		end
		exp_len = 8'((t_cols[t] + 7) / 8 - 1);
	endtask

	task automatic run_test(input int t);
		int err_before;
		err_before = errors;
		build_expected(t);
		bp_on = t_bp[t];
		done_count = 0;
		@(posedge clk);
		start <= 1'b1;
		base_addr <= t_base[t];
		num_layers <= dim_w'(t_layers[t]);
		num_rows <= dim_w'(t_rows[t]);
		num_cols <= dim_w'(t_cols[t]);
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		if (!busy) mismatch("busy low the cycle after start");
		// busy holds until done
		while (!done) begin
			if (!busy)
				mismatch("busy low before done");
			@(posedge clk);
		end
		// room for a repeated done
		repeat (3) @(posedge clk);
		if (exp_win.size() != 0)
			protocol_error($sformatf("%0d windows never arrived", exp_win.size()));
		if (exp_addr.size() != 0) protocol_error("some row fetches never happened");
		if (done_count != 1) mismatch($sformatf("done pulsed %0d times", done_count));
		if (burst_open) protocol_error("a read burst was left open");
		exp_win.delete();
		exp_layer.delete();
		exp_addr.delete();
		tests_run++;
		if (errors != err_before) tests_failed++;
		$display("test %0d %s: %0d errors", t + 1, t_name[t], errors - err_before);
	endtask

	// ------------------------------
	// stimulus and checks on the stream side
	// ------------------------------
	always @(posedge clk) begin
		if (bp_on) window_ready <= ($random(seed) & 1) != 0;
		else window_ready <= 1'b1;
	end

	always @(posedge clk) begin
		if (reset_n) begin
			// payload frozen under back-pressure
			if (stalled && (!window_valid || window_data != held_data || window_layer != held_layer))
				mismatch("window changed while stalled");
			if (window_valid && window_ready) begin
				if (exp_win.size() == 0) begin
					protocol_error("window transferred with none expected");
				end else begin
					if (window_data != exp_win[0])
						mismatch($sformatf("window %h, expected %h", window_data, exp_win[0]));
					if (window_layer != exp_layer[0])
						mismatch($sformatf("layer %0d, expected %0d", window_layer, exp_layer[0]));
					void'(exp_win.pop_front());
					void'(exp_layer.pop_front());
				end
			end
			stalled = window_valid && !window_ready;
			held_data = window_data;
			held_layer = window_layer;
			// rready only inside a data phase
			if (rready && !burst_open) protocol_error("rready high with no read burst open");
			// axi address channel
			if (arvalid && arready) begin
				if (burst_open) protocol_error("address accepted before the last burst ended");
				if (exp_addr.size() == 0) begin
					protocol_error("read address with no fetch expected");
				end else begin
					if (araddr != exp_addr[0])
						mismatch($sformatf("araddr %h, expected %h", araddr, exp_addr[0]));
					void'(exp_addr.pop_front());
				end
				if (arlen != exp_len)
					mismatch($sformatf("arlen %0d, expected %0d", arlen, exp_len));
				// 8 byte beats and incr bursts
				if (arsize != 3'd3 || arburst != 2'b01)
					mismatch($sformatf("size %0d burst %0d, expected 3 and 1", arsize, arburst));
				burst_open = 1'b1;
				beats_seen = 0;
				cur_len = arlen;
			end
			// axi data channel
			if (rvalid && rready) begin
				beats_seen++;
				if (rlast) begin
					if (beats_seen != int'(cur_len) + 1)
						mismatch($sformatf("burst of %0d beats, arlen %0d", beats_seen, cur_len));
					burst_open = 1'b0;
				end
			end
			if (done) begin
				done_count++;
				if (busy) mismatch("busy still high at done");
				if (exp_win.size() != 0) protocol_error("done came before the last window");
			end
		end
	end

	// run limit from the test lengths
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run not finished after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		t_name[0] = "single layer";
		t_base[0] = 32'h0000_0000;
		t_layers[0] = 1;
		t_rows[0] = 5;
		t_cols[0] = 10;
		t_bp[0] = 1'b0;
		t_name[1] = "three layers";
		t_base[1] = 32'h0010_3000;
		t_layers[1] = 3;
		t_rows[1] = 4;
		t_cols[1] = 17;
		t_bp[1] = 1'b0;
		t_name[2] = "random back-pressure";
		t_base[2] = 32'h0002_5000;
		t_layers[2] = 2;
		t_rows[2] = 3;
		t_cols[2] = 12;
		t_bp[2] = 1'b1;
		// random shapes on 4 KiB aligned bases
		t_name[3] = "axi requests";
		t_base[3] = $random(seed) & 32'h0fff_f000;
		t_layers[3] = 1 + {$random(seed)} % 3;
		t_rows[3] = 1 + {$random(seed)} % 4;
		t_cols[3] = 3 + {$random(seed)} % 62;
		t_bp[3] = 1'b0;
		t_name[4] = "restart";
		t_base[4] = $random(seed) & 32'h0fff_f000;
		t_layers[4] = 2;
		t_rows[4] = 2 + {$random(seed)} % 4;
		t_cols[4] = 64;
		t_bp[4] = 1'b1;
		for (int t = 0; t < 5; t++) begin
			cycle_limit += (t_layers[t] * t_rows[t] * t_cols[t] * 4
				+ t_rows[t] * t_layers[t] * 3 * 40) * 2;
		end
		repeat (3) @(posedge clk);
		reset_n <= 1'b1;
		// quiet until the first start
		repeat (6) begin
			@(posedge clk);
			if (window_valid || arvalid || rready || busy || done)
				mismatch("activity before start");
		end
		tests_run++;
		if (errors != 0) tests_failed++;
		$display("test 0 idle after reset: %0d errors", errors);
		for (int t = 0; t < 5; t++) begin
			run_test(t);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/ddr_read_model.sv */
`default_nettype none

module ddr_read_model
	import input_layer_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,
	input  logic [addr_w-1:0] araddr,
	input  logic [7:0]        arlen,
	input  logic              arvalid,
	output logic              arready = 1'b0,
	output logic              rvalid = 1'b0,
	output logic [data_w-1:0] rdata = '0,
	output logic              rlast = 1'b0,
	input  logic              rready
);
	timeunit 1ns;
	timeprecision 100ps;

	int                seed = 30710;
	logic              active = 1'b0;
	logic [addr_w-1:0] next_addr = '0;
	// beats still to present in this burst
	logic [8:0]        beats_left = '0;

	// low address byte plus the next byte up
	function automatic logic [7:0] byte_at(input logic [addr_w-1:0] a);
		return a[7:0] + a[15:8];
	endfunction

	// little endian beat, lowest address in byte 0
	function automatic logic [data_w-1:0] beat_at(input logic [addr_w-1:0] a);
		logic [data_w-1:0] d;
		for (int i = 0; i < beat_bytes; i++) begin
			d[8*i +: 8] = byte_at(a + addr_w'(i));
		end
		return d;
	endfunction

	// ------------------------------
	// single outstanding burst
	// ------------------------------
	always @(posedge clk) begin
		if (!reset_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			active <= 1'b0;
		end else if (!active) begin
			if (arvalid && arready) begin
				active <= 1'b1;
				arready <= 1'b0;
				next_addr <= araddr;
				beats_left <= 9'(arlen) + 9'd1;
			end else begin
				// address stall about one cycle in four
				arready <= ($random(seed) & 3) != 0;
			end
		end else if (!rvalid || rready) begin
			if (rvalid && rlast) begin
				active <= 1'b0;
				rvalid <= 1'b0;
				rlast <= 1'b0;
			end else if (($random(seed) & 3) != 0) begin
				rvalid <= 1'b1;
				rdata <= beat_at(next_addr);
				rlast <= (beats_left == 9'd1);
				next_addr <= next_addr + addr_w'(beat_bytes);
				beats_left <= beats_left - 9'd1;
			end else begin
				// data bubble
				rvalid <= 1'b0;
				rlast <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/input_layer_streamer.sv */
`default_nettype none

module input_layer_streamer
	import input_layer_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_n,
	// configuration, sampled with start
	input  logic                 start,
	input  logic [addr_w-1:0]    base_addr,
	input  logic [dim_w-1:0]     num_layers,
	input  logic [dim_w-1:0]     num_rows,
	input  logic [dim_w-1:0]     num_cols,
	// axi read address channel
	output logic [addr_w-1:0]    araddr,
	output logic [7:0]           arlen,
	output logic [2:0]           arsize,
	output logic [1:0]           arburst,
	output logic                 arvalid,
	input  logic                 arready,
	// axi read data channel
	input  logic                 rvalid,
	input  logic [data_w-1:0]    rdata,
	input  logic                 rlast,
	output logic                 rready,
	// window stream
	output logic [window_w-1:0]  window_data,
	output logic                 window_valid,
	input  logic                 window_ready,
	output logic [dim_w-1:0]     window_layer,
	// status
	output logic                 busy,
	output logic                 done
);

	// fetch request path
	logic                  fetch_req;
	logic [addr_w-1:0]     fetch_addr;
	logic [1:0]            fetch_slot;
	logic [beat_idx_w:0]   fetch_beats;
	logic                  fetch_done;
	// bank write path
	logic                  wr_en;
	logic [1:0]            wr_slot;
	logic [beat_idx_w-1:0] wr_beat;
	logic [data_w-1:0]     wr_data;
	// bank read path
	logic [dim_w-1:0]      rd_col;
	logic [2:0]            slot_valid;
	logic [8:0][7:0]       window_bytes;
	// output stage handshake
	logic                  load_en;
	logic                  load_ok;
	logic [dim_w-1:0]      load_layer;
	logic                  window_accept;

	// fixed burst shape, 8 byte incr beats
	assign arsize = axi_size_8b;
	assign arburst = axi_burst_incr;

	layer_sequencer seq_i (
		.clk(clk), .reset_n(reset_n), .start(start), .base_addr(base_addr),
		.num_layers(num_layers), .num_rows(num_rows), .num_cols(num_cols),
		.fetch_done(fetch_done), .load_ok(load_ok), .window_accept(window_accept),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_slot(fetch_slot),
		.fetch_beats(fetch_beats), .rd_col(rd_col), .slot_valid(slot_valid),
		.load_en(load_en), .load_layer(load_layer), .busy(busy), .done(done)
	);

	ddr_row_reader reader_i (
		.clk(clk), .reset_n(reset_n), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.fetch_slot(fetch_slot), .fetch_beats(fetch_beats), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rlast(rlast), .araddr(araddr), .arlen(arlen),
		.arvalid(arvalid), .rready(rready), .wr_en(wr_en), .wr_slot(wr_slot),
		.wr_beat(wr_beat), .wr_data(wr_data), .fetch_done(fetch_done)
	);

	row_buffer_bank bank_i (
		.clk(clk), .reset_n(reset_n), .start(start), .num_cols(num_cols),
		.wr_en(wr_en), .wr_slot(wr_slot), .wr_beat(wr_beat), .wr_data(wr_data),
		.rd_col(rd_col), .slot_valid(slot_valid), .window_bytes(window_bytes)
	);

	window_output_stage out_i (
		.clk(clk), .reset_n(reset_n), .load_en(load_en), .window_bytes(window_bytes),
		.load_layer(load_layer), .window_ready(window_ready),
		.window_data(window_data), .window_layer(window_layer),
		.window_valid(window_valid), .load_ok(load_ok), .window_accept(window_accept)
	);

endmodule

`default_nettype wire

/* verilog/window_output_stage.sv */
`default_nettype none

module window_output_stage
	import input_layer_pkg::*;
(
	input  logic                clk,
	input  logic                reset_n,
	input  logic                load_en,
	input  logic [8:0][7:0]     window_bytes,
	input  logic [dim_w-1:0]    load_layer,
	input  logic                window_ready,
	output logic [window_w-1:0] window_data,
	output logic [dim_w-1:0]    window_layer,
	output logic                window_valid,
	output logic                load_ok,
	output logic                window_accept
);

	logic [window_w-1:0] packed_window;

	// ------------------------------
	// byte packing
	// ------------------------------
	// top row first, left column in the high byte
	always_comb begin
		for (int i = 0; i < 9; i++) begin
			packed_window[window_w-1-8*i -: 8] = window_bytes[i];
		end
	end

	// handshake
	assign window_accept = window_valid && window_ready;
	// empty, or current window leaves this cycle
	assign load_ok = !window_valid || window_accept;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			window_valid <= 1'b0;
		end else if (load_en) begin
			window_valid <= 1'b1;
		end else if (window_accept) begin
			window_valid <= 1'b0;
		end
	end

	// payload held while stalled
	always_ff @(posedge clk) begin
		if (load_en) begin
			window_data <= packed_window;
			window_layer <= load_layer;
		end
	end

endmodule

`default_nettype wire

/* verilog/row_buffer_bank.sv */
`default_nettype none

module row_buffer_bank
	import input_layer_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  start,
	input  logic [dim_w-1:0]      num_cols,
	input  logic                  wr_en,
	input  logic [1:0]            wr_slot,
	input  logic [beat_idx_w-1:0] wr_beat,
	input  logic [data_w-1:0]     wr_data,
	input  logic [dim_w-1:0]      rd_col,
	input  logic [2:0]            slot_valid,
	// index is row*3 + col, 0 at top left
	output logic [8:0][7:0]       window_bytes
);

	// three rows: above, current, below
	logic [7:0]       store [0:2][0:max_cols-1];
	logic [dim_w-1:0] cfg_cols;
	logic [dim_w-1:0] col_pos [0:2];
	logic             col_in [0:2];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cfg_cols <= '0;
		end else if (start) begin
			cfg_cols <= num_cols;
		end
	end

	// little endian bytes of each beat
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < beat_bytes; i++) begin
				store[wr_slot][{wr_beat, i[col_idx_w-beat_idx_w-1:0]}] <= wr_data[8*i +: 8];
			end
		end
	end

	// ------------------------------
	// 3x3 select with zero padding
	// ------------------------------
	for (genvar k = 0; k < 3; k++) begin : g_col
		// c-1 wraps high at the left edge, so one compare covers both sides
		assign col_pos[k] = rd_col + dim_w'(k) - dim_w'(1);
		assign col_in[k] = (col_pos[k] < cfg_cols);
		for (genvar s = 0; s < 3; s++) begin : g_row
			assign window_bytes[s*3 + k] = (slot_valid[s] && col_in[k])
				? store[s][col_pos[k][col_idx_w-1:0]] : 8'd0;
		end
	end

endmodule

`default_nettype wire

/* verilog/ddr_row_reader.sv */
`default_nettype none

module ddr_row_reader
	import input_layer_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  fetch_req,
	input  logic [addr_w-1:0]     fetch_addr,
	input  logic [1:0]            fetch_slot,
	input  logic [beat_idx_w:0]   fetch_beats,
	input  logic                  arready,
	input  logic                  rvalid,
	input  logic [data_w-1:0]     rdata,
	input  logic                  rlast,
	output logic [addr_w-1:0]     araddr,
	output logic [7:0]            arlen,
	output logic                  arvalid,
	output logic                  rready,
	output logic                  wr_en,
	output logic [1:0]            wr_slot,
	output logic [beat_idx_w-1:0] wr_beat,
	output logic [data_w-1:0]     wr_data,
	output logic                  fetch_done
);

	typedef enum logic [1:0] {
		ph_idle,
		ph_addr,
		ph_data,
		ph_finish
	} rd_phase_t;

	rd_phase_t phase;
	logic      beat_ok;

	// accepted read beat goes straight into the bank
	assign beat_ok = rvalid && rready;
	assign wr_en = beat_ok;
	assign wr_data = rdata;
	// one cycle after the rlast beat
	assign fetch_done = (phase == ph_finish);

	// burst fields, captured with the request
	always_ff @(posedge clk) begin
		if ((phase == ph_idle) && fetch_req) begin
			araddr <= fetch_addr;
			arlen <= 8'(fetch_beats) - 8'd1;
			wr_slot <= fetch_slot;
		end
	end

	// ------------------------------
	// address / data / finish
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			phase <= ph_idle;
			arvalid <= 1'b0;
			rready <= 1'b0;
			wr_beat <= '0;
		end else begin
			case (phase)
				ph_idle: begin
					if (fetch_req) begin
						arvalid <= 1'b1;
						phase <= ph_addr;
					end
				end
				ph_addr: begin
					// hold address until slave takes it
					if (arready) begin
						arvalid <= 1'b0;
						rready <= 1'b1;
						wr_beat <= '0;
						phase <= ph_data;
					end
				end
				ph_data: begin
					if (beat_ok) begin
						wr_beat <= wr_beat + 1'b1;
						if (rlast) begin
							rready <= 1'b0;
							phase <= ph_finish;
						end
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/layer_sequencer.sv */
`default_nettype none

module layer_sequencer
	import input_layer_pkg::*;
(
	input  logic                clk,
	input  logic                reset_n,
	input  logic                start,
	input  logic [addr_w-1:0]   base_addr,
	input  logic [dim_w-1:0]    num_layers,
	input  logic [dim_w-1:0]    num_rows,
	input  logic [dim_w-1:0]    num_cols,
	input  logic                fetch_done,
	input  logic                load_ok,
	input  logic                window_accept,
	output logic                fetch_req,
	output logic [addr_w-1:0]   fetch_addr,
	output logic [1:0]          fetch_slot,
	output logic [beat_idx_w:0] fetch_beats,
	output logic [dim_w-1:0]    rd_col,
	output logic [2:0]          slot_valid,
	output logic                load_en,
	output logic [dim_w-1:0]    load_layer,
	output logic                busy,
	output logic                done
);

	// sampled configuration
	logic [addr_w-1:0] cfg_base;
	logic [dim_w-1:0]  cfg_layers;
	logic [dim_w-1:0]  cfg_rows;
	logic [dim_w-1:0]  cfg_cols;

	seq_state_t        state;
	logic [dim_w-1:0]  row_idx;
	logic [dim_w-1:0]  layer_idx;
	logic [dim_w-1:0]  col_idx;
	// slot being fetched, slot k holds row r-1+k
	logic [1:0]        fetch_k;
	logic [dim_w-1:0]  fetch_row;
	logic [dim_w-1:0]  row_next;
	logic              top_ok;
	logic              bot_ok;
	logic              last_fetch;
	logic              last_col;
	logic              last_layer;
	logic              last_row;

	// ------------------------------
	// position decode
	// ------------------------------
	// row above / below inside the image
	assign top_ok = (row_idx != '0);
	assign bot_ok = ((row_idx + dim_w'(1)) < cfg_rows);
	// bit 0 is the top slot
	assign slot_valid = {bot_ok, 1'b1, top_ok};

	// row r+1 is skipped at the bottom edge
	assign last_fetch = fetch_done && ((fetch_k == 2'd2) || ((fetch_k == 2'd1) && !bot_ok));
	assign last_col = (col_idx == (cfg_cols - dim_w'(1)));
	assign last_layer = (layer_idx == (cfg_layers - dim_w'(1)));
	assign last_row = (row_idx == (cfg_rows - dim_w'(1)));
	// row after this row/layer position
	assign row_next = last_layer ? row_idx + dim_w'(1) : row_idx;

	// ------------------------------
	// fetch request fields
	// ------------------------------
	assign fetch_row = row_idx + dim_w'(fetch_k) - dim_w'(1);
	// base + layer block + row slot
	assign fetch_addr = cfg_base + (addr_w'(layer_idx) << layer_stride_shift)
		+ (addr_w'(fetch_row) << row_stride_shift);
	assign fetch_slot = fetch_k;
	// columns rounded up to whole beats
	assign fetch_beats = (beat_idx_w + 1)'((cfg_cols + dim_w'(beat_bytes - 1)) >> beat_idx_w);

	// one load per cycle the output stage allows
	assign load_en = (state == seq_stream) && load_ok;
	assign rd_col = col_idx;
	assign load_layer = layer_idx;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cfg_base <= '0;
			cfg_layers <= '0;
			cfg_rows <= '0;
			cfg_cols <= '0;
		end else if ((state == seq_idle) && start) begin
			cfg_base <= base_addr;
			cfg_layers <= num_layers;
			cfg_rows <= num_rows;
			cfg_cols <= num_cols;
		end
	end

	// ------------------------------
	// traversal fsm
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= seq_idle;
			fetch_req <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			row_idx <= '0;
			layer_idx <= '0;
			col_idx <= '0;
			fetch_k <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				seq_idle: begin
					if (start) begin
						state <= seq_fetch;
						fetch_req <= 1'b1;
						busy <= 1'b1;
						row_idx <= '0;
						layer_idx <= '0;
						col_idx <= '0;
						// row 0 has nothing above
						fetch_k <= 2'd1;
					end
				end
				seq_fetch: begin
					if (last_fetch) begin
						fetch_req <= 1'b0;
						state <= seq_stream;
					end else if (fetch_done) begin
						// request stays up, next row of the slot set
						fetch_k <= fetch_k + 2'd1;
					end
				end
				seq_stream: begin
					if (load_en && !last_col) begin
						col_idx <= col_idx + dim_w'(1);
					end else if (load_en) begin
						col_idx <= '0;
						if (last_layer && last_row) begin
							state <= seq_done;
						end else begin
							// next layer of same row, or layer 0 of next row
							layer_idx <= last_layer ? '0 : layer_idx + dim_w'(1);
							row_idx <= row_next;
							fetch_k <= (row_next != '0) ? 2'd0 : 2'd1;
							fetch_req <= 1'b1;
							state <= seq_fetch;
						end
					end
				end
				seq_done: begin
					// last window still in the output register
					if (window_accept) begin
						done <= 1'b1;
						busy <= 1'b0;
						state <= seq_idle;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* common/input_layer_pkg.sv */
`default_nettype none

package input_layer_pkg;

	// ------------------------------
	// axi side
	// ------------------------------
	localparam int addr_w = 32;
	localparam int data_w = 64;
	// bytes per read beat
	localparam int beat_bytes = 8;
	localparam logic [2:0] axi_size_8b = 3'd3;
	localparam logic [1:0] axi_burst_incr = 2'b01;

	// ------------------------------
	// feature map geometry
	// ------------------------------
	// row slot size, also widest row
	localparam int max_cols = 64;
	// row, column and layer counters
	localparam int dim_w = 10;
	// one layer per 4 KiB block
	localparam int layer_stride_shift = 12;
	// one row per 64 byte slot
	localparam int row_stride_shift = 6;
	localparam int col_idx_w = 6;
	localparam int beat_idx_w = 3;
	// nine bytes of 3x3 window
	localparam int window_w = 72;

	// traversal control states
	typedef enum logic [1:0] {
		seq_idle,
		seq_fetch,
		seq_stream,
		seq_done
	} seq_state_t;

endpackage

`default_nettype wire
